// File: files.f
common/tcb_pkg.sv
common/map_pkg.sv
design/tcb_decoder.sv
tcb_demux/tcb_demux.sv
design/tcb_mem.sv
design/tcb_regs.sv
design/tcb_system.sv
test/tcb_system_tb.sv

// File: Makefile
# Verilator build and run of the bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_system_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tcb_system_tb.sv
// bus subsystem testbench
// table of transfers with model-derived expected responses, applied with
// random idle gaps and checked one cycle after acceptance

`timescale 1ns/1ns

module tcb_system_tb;

    localparam int unsigned RST_CYC = 16;
    localparam logic [tcb_pkg::ADR_W-1:0] MEM_TOP = 16'(map_pkg::MEM_WORDS * 4);

    // one table row, request plus expected response
    typedef struct packed {
        tcb_pkg::tcb_req_t req;
        tcb_pkg::tcb_rsp_t rsp;
    } entry_t;

    logic              sub;
    logic              rst;
    logic              vld;
    tcb_pkg::tcb_req_t req;
    logic              rdy;
    tcb_pkg::tcb_rsp_t rsp;

    entry_t tbl [$];
    int     cycles;
    int     cyc_limit;

    // reference model state
    logic [tcb_pkg::DAT_W-1:0] ref_mem [map_pkg::MEM_WORDS];
    logic [tcb_pkg::DAT_W-1:0] ref_scratch;
    logic [tcb_pkg::DAT_W-1:0] ref_count;

    tcb_system i_tcb_system (
        .sub (sub),
        .rst (rst),
        .vld (vld),
        .req (req),
        .rdy (rdy),
        .rsp (rsp)
    );

    always #20 sub = ~sub;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [tcb_pkg::DAT_W-1:0] byte_merge(
        input logic [tcb_pkg::DAT_W-1:0] old,
        input logic [tcb_pkg::DAT_W-1:0] wdt,
        input logic [tcb_pkg::BYT_W-1:0] byt
    );
        logic [tcb_pkg::DAT_W-1:0] res;
        res = old;
        for (int b = 0; b < tcb_pkg::BYT_W; b++) begin
            if (byt[b]) res[8*b +: 8] = wdt[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic targets_regs(input logic [tcb_pkg::ADR_W-1:0] adr);
        return adr >= MEM_TOP;
    endfunction

    // expected response, advances the model by one transfer
    task automatic model_step(input tcb_pkg::tcb_req_t r, output tcb_pkg::tcb_rsp_t e);
        logic wr;
        logic [7:0] word;
        e    = '0;
        wr   = (r.op == tcb_pkg::OP_WRITE);
        word = r.adr[9:2];
        if (!targets_regs(r.adr)) begin
            if (wr) ref_mem[word] = byte_merge(ref_mem[word], r.wdt, r.byt);
            else    e.rdt = ref_mem[word];
        end else begin
            // outside the 16 byte window
            if ((r.adr >> 4) != (map_pkg::REG_BASE >> 4)) begin
                e.err = 1'b1;
            end else begin
                case (map_pkg::reg_e'(r.adr[3:2]))
                    map_pkg::REG_ID: begin
                        if (wr) e.err = 1'b1;
                        else    e.rdt = map_pkg::REG_ID_VALUE;
                    end
                    map_pkg::REG_SCRATCH: begin
                        if (wr) ref_scratch = byte_merge(ref_scratch, r.wdt, r.byt);
                        else    e.rdt = ref_scratch;
                    end
                    map_pkg::REG_COUNT: begin
                        if (wr) e.err = 1'b1;
                        else    e.rdt = ref_count;
                    end
                    default: e.err = 1'b1;
                endcase
            end
            // counted after the read, errors too
            ref_count = ref_count + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // table building
    ////////////////////////////////////////////////////////////

    task automatic add_entry(input tcb_pkg::tcb_op_e op, input logic [15:0] adr,
                             input logic [3:0] byt, input logic [31:0] wdt);
        entry_t e;
        e.req.op  = op;
        e.req.adr = adr;
        e.req.byt = byt;
        e.req.wdt = wdt;
        model_step(e.req, e.rsp);
        tbl.push_back(e);
    endtask

    task automatic add_read(input logic [15:0] adr);
        add_entry(tcb_pkg::OP_READ, adr, 4'hf, 32'h0);
    endtask

    task automatic add_write(input logic [15:0] adr, input logic [3:0] byt);
        add_entry(tcb_pkg::OP_WRITE, adr, byt, $urandom);
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic report_failure();
        $display("TESTBENCH FAILED");
    endtask

    task automatic check_rsp(input tcb_pkg::tcb_rsp_t exp, input tcb_pkg::tcb_rsp_t got,
                             input int idx);
        if (got !== exp) begin
            $display("Fail rsp entry %0d: expected rdt=%h err=%h, got rdt=%h err=%h",
                     idx, exp.rdt, exp.err, got.rdt, got.err);
            report_failure();
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_rdy(input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail rdy: expected %h, got %h", exp, got);
            report_failure();
            $fatal(1, "ready mismatch");
        end
    endtask

    // watchdog on the whole run
    always @(posedge sub) begin
        cycles = cycles + 1;
        if (cycles > cyc_limit) begin
            $display("run did not finish within %0d cycles", cyc_limit);
            report_failure();
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int   k;
        int   pend_idx;
        int   n_stall;
        logic pend;
        logic stall;
        logic was_idle;
        logic reg_busy;
        sub         = 1'b0;
        rst         = 1'b1;
        vld         = 1'b0;
        req         = '0;
        cycles      = 0;
        ref_scratch = '0;
        ref_count   = '0;
        void'($urandom(32'h814c_b375));

        // reset values first
        add_read(16'h0408);
        add_read(16'h0404);
        add_read(16'h0400);
        // memory, full then partial writes
        add_write(16'h0010, 4'hf);
        add_read(16'h0010);
        add_write(16'h0010, 4'b0101);
        add_read(16'h0010);
        add_write(16'h03fc, 4'hf);
        add_write(16'h03fc, 4'b0110);
        add_read(16'h03fc);
        add_write(16'h0000, 4'hf);
        add_read(16'h0000);
        // scratch round trip
        add_write(16'h0404, 4'hf);
        add_read(16'h0404);
        add_write(16'h0404, 4'b0011);
        add_read(16'h0404);
        add_read(16'h0408);
        // error cases
        add_write(16'h0400, 4'hf);
        add_write(16'h0408, 4'hf);
        add_read(16'h040c);
        add_write(16'h040c, 4'hf);
        add_read(16'h0800);
        add_write(16'h1234, 4'hf);
        add_read(16'hfff0);
        add_read(16'h0408);
        // alternate memory and registers
        for (int j = 0; j < 6; j++) begin
            add_write(16'h0100 + 16'(4 * j), 4'hf);
            add_write(16'h0404, 4'hf);
        end
        for (int j = 0; j < 6; j++) begin
            add_read(16'h0100 + 16'(4 * j));
            add_read(16'h0408);
        end
        // register runs, each one stalls
        add_read(16'h0400);
        add_read(16'h0404);
        add_read(16'h0408);
        add_read(16'h0400);

        // at most idle, stall and accept per row
        cyc_limit = 4 * tbl.size() + RST_CYC;

        repeat (RST_CYC) @(posedge sub);
        @(negedge sub);
        rst = 1'b0;

        k        = 0;
        pend     = 1'b0;
        pend_idx = 0;
        stall    = 1'b0;
        was_idle = 1'b0;
        reg_busy = 1'b0;
        n_stall  = 0;
        while (k < tbl.size() || pend) begin
            @(negedge sub);
            // response of the transfer on the last rising edge
            if (pend) check_rsp(tbl[pend_idx].rsp, rsp, pend_idx);
            pend = 1'b0;
            // a stalled request stays as it is
            if (!stall) begin
                if (k < tbl.size() && (was_idle || ($urandom % 4) != 0)) begin
                    vld      = 1'b1;
                    req      = tbl[k].req;
                    was_idle = 1'b0;
                end else begin
                    vld      = 1'b0;
                    req      = '0;
                    was_idle = 1'b1;
                end
            end
            #1;
            check_rdy(!(reg_busy && targets_regs(req.adr)), rdy);
            if (vld && rdy) begin
                pend     = 1'b1;
                pend_idx = k;
                reg_busy = targets_regs(req.adr);
                stall    = 1'b0;
                k++;
            end else begin
                stall    = vld;
                reg_busy = 1'b0;
                if (vld) n_stall++;
            end
        end

        if (n_stall == 0) begin
            $display("no back-pressure cycle was seen on rdy");
            report_failure();
            $fatal(1, "missing back-pressure");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: design/tcb_system.sv
// bus subsystem top level
// decoder and demux fan one manager port out to memory and registers

`timescale 1ns/1ns

module tcb_system (
    input  logic              sub,
    input  logic              rst,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    map_pkg::dev_e                             dec_sel;
    logic              [map_pkg::DEV_N-1:0]    man_vld;
    tcb_pkg::tcb_req_t [map_pkg::DEV_N-1:0]    man_req;
    logic              [map_pkg::DEV_N-1:0]    man_rdy;
    tcb_pkg::tcb_rsp_t [map_pkg::DEV_N-1:0]    man_rsp;

    // address to device
    tcb_decoder i_tcb_decoder (
        .adr (req.adr),
        .sel (dec_sel)
    );

    // request fan out, response return
    tcb_demux #(
        .IFN (map_pkg::DEV_N)
    ) i_tcb_demux (
        .sub     (sub),
        .rst     (rst),
        .sel     (dec_sel),
        .sub_vld (vld),
        .sub_req (req),
        .sub_rdy (rdy),
        .sub_rsp (rsp),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp)
    );

    tcb_mem i_tcb_mem (
        .sub (sub),
        .rst (rst),
        .vld (man_vld[map_pkg::DEV_MEM]),
        .req (man_req[map_pkg::DEV_MEM]),
        .rdy (man_rdy[map_pkg::DEV_MEM]),
        .rsp (man_rsp[map_pkg::DEV_MEM])
    );

    // also catches unmapped addresses
    tcb_regs i_tcb_regs (
        .sub (sub),
        .rst (rst),
        .vld (man_vld[map_pkg::DEV_REG]),
        .req (man_req[map_pkg::DEV_REG]),
        .rdy (man_rdy[map_pkg::DEV_REG]),
        .rsp (man_rsp[map_pkg::DEV_REG])
    );

endmodule

// File: design/tcb_regs.sv
// register block subordinate
// identity, scratch and transfer counter registers, plus the error
// response for illegal accesses and unmapped addresses

`timescale 1ns/1ns

module tcb_regs (
    input  logic              sub,
    input  logic              rst,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    logic                      trn;
    logic                      wen;
    logic                      busy;
    logic                      in_win;
    map_pkg::reg_e             ofs;
    logic [tcb_pkg::DAT_W-1:0] scratch;
    logic [tcb_pkg::DAT_W-1:0] count;
    logic [tcb_pkg::DAT_W-1:0] rdt_nxt;
    logic                      err_nxt;

    ////////////////////////////////////////////////////////////
    // handshake and decode
    ////////////////////////////////////////////////////////////

    // one wait cycle after every transfer
    assign rdy = !busy;
    assign trn = vld && rdy;
    assign wen = (req.op == tcb_pkg::OP_WRITE);

    // 16 byte window at REG_BASE
    assign in_win = (req.adr[tcb_pkg::ADR_W-1:map_pkg::REG_OFS_W]
                  == map_pkg::REG_BASE[tcb_pkg::ADR_W-1:map_pkg::REG_OFS_W]);
    assign ofs    = map_pkg::reg_e'(req.adr[3:2]);

    // read mux and error rule
    always_comb begin
        rdt_nxt = '0;
        err_nxt = 1'b0;
        if (!in_win) begin
            err_nxt = 1'b1;
        end else begin
            case (ofs)
                map_pkg::REG_ID: begin
                    // read only
                    if (wen) err_nxt = 1'b1;
                    else     rdt_nxt = map_pkg::REG_ID_VALUE;
                end
                map_pkg::REG_SCRATCH: begin
                    if (!wen) rdt_nxt = scratch;
                end
                map_pkg::REG_COUNT: begin
                    // value before this transfer is counted
                    if (wen) err_nxt = 1'b1;
                    else     rdt_nxt = count;
                end
                // offset 3 is unmapped
                default: err_nxt = 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (rst) begin
            busy    <= 1'b0;
            count   <= '0;
            scratch <= '0;
        end else begin
            busy <= trn;
            // errors count too
            if (trn) begin
                count <= count + 1;
            end
            if (trn && wen && !err_nxt && ofs == map_pkg::REG_SCRATCH) begin
                for (int b = 0; b < tcb_pkg::BYT_W; b++) begin
                    if (req.byt[b]) begin
                        scratch[8*b +: 8] <= req.wdt[8*b +: 8];
                    end
                end
            end
        end
    end

    // response for the cycle after the transfer
    always_ff @(posedge sub) begin
        if (trn) begin
            rsp <= '{rdt: rdt_nxt, err: err_nxt};
        end
    end

    // a request stalled by the busy cycle stays in place until taken
    a_hold: assert property (@(posedge sub) disable iff (rst)
        (vld && !rdy) |=> (vld && $stable(req)));

endmodule

// File: design/tcb_mem.sv
// word memory subordinate
// byte-enabled writes, registered reads, always ready, never errors

`timescale 1ns/1ns

module tcb_mem (
    input  logic              sub,
    input  logic              rst,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    logic                      trn;
    logic                      wen;
    logic [map_pkg::MEM_AW-1:0] idx;
    logic [tcb_pkg::DAT_W-1:0] rdt_q;

    // storage, contents undefined after reset
    logic [tcb_pkg::DAT_W-1:0] mem [map_pkg::MEM_WORDS];

    ////////////////////////////////////////////////////////////
    // handshake and decode
    ////////////////////////////////////////////////////////////

    // no wait states
    assign rdy = 1'b1;
    assign trn = vld && rdy;
    assign wen = (req.op == tcb_pkg::OP_WRITE);

    // word index, adr[9:2]
    assign idx = req.adr[map_pkg::MEM_AW+1:2];

    ////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////

    // write only the enabled byte lanes
    always_ff @(posedge sub) begin
        if (trn && wen) begin
            for (int b = 0; b < tcb_pkg::BYT_W; b++) begin
                if (req.byt[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    // read data for the response cycle, zero on writes
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt_q <= wen ? '0 : mem[idx];
        end
    end

    assign rsp = '{rdt: rdt_q, err: 1'b0};

    // a write with no lanes enabled is a manager bug
    a_wr_byt: assert property (@(posedge sub) disable iff (rst)
        (trn && wen) |-> (req.byt != '0));

endmodule

// File: tcb_demux/tcb_demux.sv
// bus demultiplexer
// steers one manager request to the selected subordinate and
// returns that subordinate's response one cycle after the transfer

`timescale 1ns/1ns

module tcb_demux #(
    parameter int unsigned IFN = map_pkg::DEV_N
) (
    input  logic                          sub,
    input  logic                          rst,
    // subordinate select, from the decoder
    input  logic [$clog2(IFN)-1:0]        sel,
    // manager side connects here
    input  logic                          sub_vld,
    input  tcb_pkg::tcb_req_t             sub_req,
    output logic                          sub_rdy,
    output tcb_pkg::tcb_rsp_t             sub_rsp,
    // subordinate devices connect here
    output logic              [IFN-1:0]   man_vld,
    output tcb_pkg::tcb_req_t [IFN-1:0]   man_req,
    input  logic              [IFN-1:0]   man_rdy,
    input  tcb_pkg::tcb_rsp_t [IFN-1:0]   man_rsp
);

    localparam int unsigned IFL = $clog2(IFN);

    logic           sub_trn;
    // select of the transfer whose response is due
    logic [IFL-1:0] man_sel;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    assign sub_trn = sub_vld && sub_rdy;

    // remember target for the response cycle
    always_ff @(posedge sub) begin
        if (rst) begin
            man_sel <= IFL'(map_pkg::DEV_MEM);
        end else if (sub_trn) begin
            man_sel <= sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // request
    ////////////////////////////////////////////////////////////

    // only the selected subordinate sees valid and payload
    for (genvar i = 0; i < IFN; i++) begin : gen_req
        assign man_vld[i] = (sel == IFL'(i)) ? sub_vld : 1'b0;
        assign man_req[i] = (sel == IFL'(i)) ? sub_req : '0;
    end

    // ready comes straight from the current target
    assign sub_rdy = man_rdy[sel];

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    assign sub_rsp = man_rsp[man_sel];

    // a stalled request must not move, else the select and the
    // payload seen by the subordinate could drift apart
    a_req_stable: assert property (@(posedge sub) disable iff (rst)
        (sub_vld && !sub_rdy) |=> (sub_vld && $stable(sel) && $stable(sub_req)));

endmodule

// File: design/tcb_decoder.sv
// address decoder
// maps a request address onto the subordinate that serves it

`timescale 1ns/1ns

module tcb_decoder (
    input  logic [tcb_pkg::ADR_W-1:0] adr,
    output map_pkg::dev_e             sel
);

    // upper address bits above the memory window
    logic [tcb_pkg::ADR_W-1:0] adr_hi;
    logic                      in_mem;

    ////////////////////////////////////////////////////////////
    // window compare
    ////////////////////////////////////////////////////////////

    // byte address bits inside the memory are masked off
    assign adr_hi = adr >> (map_pkg::MEM_AW + 2);

    // all upper bits zero means below MEM_WORDS*4
    assign in_mem = (adr_hi == '0);

    ////////////////////////////////////////////////////////////
    // select
    ////////////////////////////////////////////////////////////

    // anything outside memory goes to the register block,
    // which answers unmapped addresses with an error
    always_comb begin
        if (in_mem) begin
            sel = map_pkg::DEV_MEM;
        end else begin
            sel = map_pkg::DEV_REG;
        end
    end

endmodule

// File: common/map_pkg.sv
// system address map
// device selection codes, memory size and register block layout

package map_pkg;

    // subordinate index, also the demux select
    typedef enum logic [0:0] {
        DEV_MEM = 1'b0,
        DEV_REG = 1'b1
    } dev_e;

    localparam int unsigned DEV_N = 2;

    // word memory at the bottom of the map, 1 KB
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

    // register block, 16 byte window
    localparam logic [tcb_pkg::ADR_W-1:0] REG_BASE  = 16'h0400;
    localparam int unsigned               REG_OFS_W = 4;

    // word offsets inside the window, adr[3:2]
    typedef enum logic [1:0] {
        REG_ID      = 2'd0,
        REG_SCRATCH = 2'd1,
        REG_COUNT   = 2'd2
    } reg_e;

    localparam logic [tcb_pkg::DAT_W-1:0] REG_ID_VALUE = 32'h7cb1_0001;

endpackage

// File: common/tcb_pkg.sv
// tightly coupled bus definitions
// widths, operation encoding and the request and response payloads

package tcb_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    // byte address
    localparam int unsigned ADR_W = 16;
    // data word
    localparam int unsigned DAT_W = 32;
    // one enable per data byte
    localparam int unsigned BYT_W = DAT_W / 8;

    ////////////////////////////////////////////////////////////
    // payload types
    ////////////////////////////////////////////////////////////

    // transfer direction
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } tcb_op_e;

    // request, held stable by the manager until ready
    typedef struct packed {
        tcb_op_e          op;
        logic [ADR_W-1:0] adr;
        logic [BYT_W-1:0] byt;
        logic [DAT_W-1:0] wdt;
    } tcb_req_t;

    // response, valid one cycle after the transfer
    typedef struct packed {
        logic [DAT_W-1:0] rdt;
        logic             err;
    } tcb_rsp_t;

endpackage
